// File: sim.f
+incdir+include
logic/dcache_pkg.sv
logic/dcache_way_store.sv
logic/dcache_lookup.sv
logic/dcache_miss_ctrl.sv
logic/dcache_read_return.sv
logic/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

// File: sim/dcache_tb.sv
module dcache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAND_REQS   = 200;
    localparam int REQ_TOTAL   = 40 + RAND_REQS;
    localparam int MISS_CYCLES = 48;                  // write-back, refill and slack
    localparam int LIMIT       = REQ_TOTAL * MISS_CYCLES + 100;

    logic clk = 1'b0;
    logic resetn, valid, op;
    dcache_pkg::index_t index;
    dcache_pkg::tag_t tag;
    dcache_pkg::offset_t offset;
    dcache_pkg::strb_t wstrb;
    dcache_pkg::word_t wdata, rdata, rd_addr, ret_data, wr_addr;
    dcache_pkg::line_t wr_data, wb_expect;
    logic addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;

    dcache_pkg::word_t ref_mem [logic [31:0]];
    logic              exp_op [64];
    dcache_pkg::word_t exp_word [64];
    logic [5:0]        wr_ptr, rd_ptr, pend;
    logic              hit_phase, no_wb_phase;
    int                value_errs, other_errs, wb_count, cycles;
    string             test_name;

    always #4 clk = ~clk;

    dcache_top dut_i (.*);

    dcache_mem_model mem_i (
        .clk(clk), .resetn(resetn), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data), .wr_req(wr_req),
        .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    function automatic dcache_pkg::word_t addr_hash(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5bd1e995;
    endfunction

    function automatic dcache_pkg::word_t ref_word(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : addr_hash(a);
    endfunction

    assign pend = wr_ptr - rd_ptr;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wb_expect[32*b +: 32] = ref_word(wr_addr + 4 * b);
        end
    end

    // expected responses in request order
    always @(posedge clk) begin
        logic [31:0]       a;
        dcache_pkg::word_t w;
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            a = {tag, index, offset[3:2], 2'b00};
            if (data_ok) rd_ptr <= rd_ptr + 1'b1;
            if (wr_req && wr_rdy) wb_count++;
            if (valid && addr_ok) begin
                exp_op[wr_ptr] <= op;
                if (op) begin
                    w = ref_word(a);
                    for (int k = 0; k < 4; k++) begin
                        if (wstrb[k]) w[8*k +: 8] = wdata[8*k +: 8];
                    end
                    ref_mem[a] = w;
                end else begin
                    exp_word[wr_ptr] <= ref_word(a);
                end
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        data_ok && !exp_op[rd_ptr] |-> rdata == exp_word[rd_ptr])
    else begin
        value_errs++;
        $display("[ERROR] %s: rdata expected %h actual %h", test_name,
                 $sampled(exp_word[rd_ptr]), $sampled(rdata));
    end

    assert property (@(posedge clk) disable iff (!resetn) data_ok |-> pend != 0)
    else begin
        other_errs++;
        $display("%s: data_ok rose with no request outstanding", test_name);
    end

    assert property (@(posedge clk) disable iff (!resetn) rd_req |-> rd_addr[3:0] == 4'h0)
    else begin
        other_errs++;
        $display("%s: refill address %h is not line aligned", test_name, $sampled(rd_addr));
    end

    assert property (@(posedge clk) disable iff (!resetn)
        wr_req && wr_rdy |-> wr_data == wb_expect)
    else begin
        value_errs++;
        $display("[ERROR] %s: wr_data expected %h actual %h", test_name,
                 $sampled(wb_expect), $sampled(wr_data));
    end

    // stores answer in their lookup cycle, hit or miss
    assert property (@(posedge clk) disable iff (!resetn)
        valid && addr_ok && op |=> data_ok)
    else begin
        other_errs++;
        $display("%s: store was not acknowledged in its lookup cycle", test_name);
    end

    assert property (@(posedge clk) disable iff (!resetn)
        hit_phase && valid && addr_ok |=> data_ok)
    else begin
        other_errs++;
        $display("%s: read hit did not answer one cycle after acceptance", test_name);
    end

    assert property (@(posedge clk) disable iff (!resetn) hit_phase |-> !rd_req)
    else begin
        other_errs++;
        $display("%s: refill requested on a resident line", test_name);
    end

    assert property (@(posedge clk) disable iff (!resetn) no_wb_phase |-> !wr_req)
    else begin
        other_errs++;
        $display("%s: write-back raised for a clean victim", test_name);
    end

    task automatic issue(input logic w, input logic [31:0] a, input dcache_pkg::strb_t s,
                         input dcache_pkg::word_t d);
        valid  <= 1'b1;
        op     <= w;
        tag    <= a[31:12];
        index  <= a[11:4];
        offset <= a[3:0];
        wstrb  <= s;
        wdata  <= d;
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
    endtask

    task automatic settle();
        valid <= 1'b0;
        do @(posedge clk); while (pend != 0 || !addr_ok || rd_req || wr_req);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int wb_before;
        void'($urandom(45));
        {resetn, valid, op, index, tag, offset, wstrb, wdata} = '0;
        {hit_phase, no_wb_phase, value_errs, other_errs, wb_count, cycles} = '0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        test_name = "cold_read_miss";
        issue(1'b0, 32'h0000_5014, 4'h0, '0);
        settle();

        test_name = "read_hit";
        hit_phase <= 1'b1;
        issue(1'b0, 32'h0000_5014, 4'h0, '0);
        issue(1'b0, 32'h0000_5018, 4'h0, '0);
        issue(1'b0, 32'h0000_5010, 4'h0, '0);
        valid <= 1'b0;
        @(posedge clk);
        hit_phase <= 1'b0;
        settle();

        test_name = "write_hit_read";
        issue(1'b1, 32'h0000_5014, 4'b0101, 32'hdead_beef);
        issue(1'b0, 32'h0000_5014, 4'h0, '0);
        settle();

        test_name = "write_miss_allocate";
        issue(1'b1, 32'h0007_0068, 4'b1100, 32'h1234_5678);
        issue(1'b0, 32'h0007_0068, 4'h0, '0);
        issue(1'b0, 32'h0007_0064, 4'h0, '0);
        settle();

        test_name = "dirty_eviction";
        wb_before = wb_count;
        for (int t = 1; t <= 8; t++) begin
            issue(1'b1, {20'(t), 8'h09, 4'h4}, 4'hf, $urandom);
            settle();
        end
        assert (wb_count != wb_before)
        else begin
            other_errs++;
            $display("%s: no write-back seen after eight dirty misses", test_name);
        end

        test_name = "clean_eviction";
        no_wb_phase <= 1'b1;
        for (int t = 1; t <= 6; t++) begin
            issue(1'b0, {20'(t), 8'h14, 4'h8}, 4'h0, '0);
            settle();
        end
        no_wb_phase <= 1'b0;

        test_name = "random_mix";
        for (int i = 0; i < RAND_REQS; i++) begin
            issue($urandom % 2, {20'($urandom % 4), 8'(3 + $urandom % 2), 2'($urandom), 2'b00},
                  $urandom_range(1, 15), $urandom);
            if ($urandom % 4 == 0) begin
                valid <= 1'b0;
                @(posedge clk);
            end
        end
        settle();
        repeat (4) @(posedge clk);

        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sim/dcache_mem_model.sv
module dcache_mem_model (
    input  logic                clk,
    input  logic                resetn,
    input  logic                rd_req,
    input  dcache_pkg::word_t   rd_addr,
    output logic                rd_rdy,
    output logic                ret_valid,
    output logic                ret_last,
    output dcache_pkg::word_t   ret_data,
    input  logic                wr_req,
    input  dcache_pkg::word_t   wr_addr,
    input  dcache_pkg::line_t   wr_data,
    output logic                wr_rdy
);

    timeunit 1ns;
    timeprecision 100ps;

    dcache_pkg::word_t shadow [logic [31:0]];
    logic [1:0]        rd_phase;   // 0 idle, 1 delay, 2 beats
    int                rd_delay;
    logic [31:0]       line_addr;
    logic [1:0]        beat_cnt;

    // initial contents, a mix of every address bit
    function automatic dcache_pkg::word_t addr_hash(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5bd1e995;
    endfunction

    function automatic dcache_pkg::word_t shadow_word(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : addr_hash(a);
    endfunction

    // refill responder, waits until no write-back is pending
    always @(posedge clk) begin
        if (!resetn) begin
            rd_phase  <= 2'd0;
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_data  <= '0;
            beat_cnt  <= '0;
            rd_delay  <= 0;
        end else begin
            case (rd_phase)
                2'd0: begin
                    ret_valid <= 1'b0;
                    ret_last  <= 1'b0;
                    if (rd_req && !wr_req) begin
                        rd_delay  <= $urandom % 6;
                        line_addr <= rd_addr;
                        rd_phase  <= 2'd1;
                    end
                end
                2'd1: begin
                    if (rd_rdy && rd_req) begin
                        rd_rdy   <= 1'b0;
                        beat_cnt <= '0;
                        rd_phase <= 2'd2;
                    end else if (rd_delay == 0) begin
                        rd_rdy <= 1'b1;
                    end else begin
                        rd_delay <= rd_delay - 1;
                    end
                end
                default: begin
                    ret_valid <= 1'b1;
                    ret_data  <= shadow_word(line_addr + 4 * beat_cnt);
                    ret_last  <= beat_cnt == 2'd3;
                    beat_cnt  <= beat_cnt + 1'b1;
                    if (beat_cnt == 2'd3) begin
                        rd_phase <= 2'd0;
                    end
                end
            endcase
        end
    end

    // write-back capture, ready most cycles
    always @(posedge clk) begin
        if (!resetn) begin
            wr_rdy <= 1'b0;
        end else begin
            wr_rdy <= ($urandom % 4) != 0;
            if (wr_req && wr_rdy) begin
                for (int b = 0; b < 4; b++) begin
                    shadow[wr_addr + 4 * b] = wr_data[32*b +: 32];
                end
            end
        end
    end

endmodule

// File: logic/dcache_top.sv
module dcache_top (
    input  logic                clk,
    input  logic                resetn,
    // cpu side
    input  logic                valid,
    input  logic                op,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::strb_t   wstrb,
    input  dcache_pkg::word_t   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    // line read bus
    output logic                rd_req,
    output dcache_pkg::word_t   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  dcache_pkg::word_t   ret_data,
    // line write bus
    output logic                wr_req,
    output dcache_pkg::word_t   wr_addr,
    output dcache_pkg::line_t   wr_data,
    input  logic                wr_rdy
);

    dcache_pkg::cpu_req_t    req;
    dcache_pkg::cpu_req_t    req_lat;
    logic                    rd_en;
    dcache_pkg::index_t      rd_index;
    dcache_pkg::way_q_t      way0_q;
    dcache_pkg::way_q_t      way1_q;
    dcache_pkg::way_wr_t     way0_wr;
    dcache_pkg::way_wr_t     way1_wr;
    logic                    hit;
    dcache_pkg::way_sel_t    hit_way;
    dcache_pkg::wbuf_t       wbuf;
    dcache_pkg::main_state_e state;
    dcache_pkg::bank_t       beat;

    assign req = {op, index, tag, offset, wstrb, wdata};

    dcache_way_store way0_i (
        .clk(clk), .resetn(resetn), .rd_en(rd_en), .rd_index(rd_index), .wr(way0_wr), .q(way0_q)
    );

    dcache_way_store way1_i (
        .clk(clk), .resetn(resetn), .rd_en(rd_en), .rd_index(rd_index), .wr(way1_wr), .q(way1_q)
    );

    dcache_lookup lookup_i (
        .clk(clk), .resetn(resetn), .valid(valid), .req(req), .state(state),
        .way0_q(way0_q), .way1_q(way1_q), .addr_ok(addr_ok), .rd_en(rd_en),
        .rd_index(rd_index), .req_lat(req_lat), .hit(hit), .hit_way(hit_way), .wbuf(wbuf)
    );

    // rd_en doubles as the accept strobe
    dcache_miss_ctrl miss_ctrl_i (
        .clk(clk), .resetn(resetn), .valid(rd_en), .req_lat(req_lat), .hit(hit), .wbuf(wbuf),
        .way0_q(way0_q), .way1_q(way1_q), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
        .ret_last(ret_last), .ret_data(ret_data), .wr_rdy(wr_rdy), .state(state), .beat(beat),
        .way0_wr(way0_wr), .way1_wr(way1_wr), .rd_req(rd_req), .rd_addr(rd_addr),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    dcache_read_return read_return_i (
        .state(state), .req_lat(req_lat), .hit(hit), .hit_way(hit_way), .way0_q(way0_q),
        .way1_q(way1_q), .beat(beat), .ret_valid(ret_valid), .ret_data(ret_data),
        .rdata(rdata), .data_ok(data_ok)
    );

endmodule

// File: logic/dcache_read_return.sv
`include "dcache_params.svh"

module dcache_read_return (
    input  dcache_pkg::main_state_e state,
    input  dcache_pkg::cpu_req_t    req_lat,
    input  logic                    hit,
    input  dcache_pkg::way_sel_t    hit_way,
    input  dcache_pkg::way_q_t      way0_q,
    input  dcache_pkg::way_q_t      way1_q,
    input  dcache_pkg::bank_t       beat,
    input  logic                    ret_valid,
    input  dcache_pkg::word_t       ret_data,
    output dcache_pkg::word_t       rdata,
    output logic                    data_ok
);

    dcache_pkg::bank_t req_bank;
    dcache_pkg::line_t hit_line;
    dcache_pkg::word_t hit_word;
    logic              in_lookup;
    logic              refill_match;

    assign req_bank  = req_lat.offset[`DC_OFFSET_W-1:2];
    assign in_lookup = state == dcache_pkg::LOOKUP;

    // and-or select, hit_way is one-hot
    assign hit_line = ({`DC_LINE_W{hit_way[0]}} & way0_q.line) |
                      ({`DC_LINE_W{hit_way[1]}} & way1_q.line);
    assign hit_word = hit_line[req_bank*`DC_WORD_W +: `DC_WORD_W];

    assign rdata = (in_lookup && hit) ? hit_word : ret_data;

    // load miss answers on the beat carrying its word
    assign refill_match = state == dcache_pkg::REFILL && ret_valid && !req_lat.op &&
                          beat == req_bank;

    assign data_ok = (in_lookup && (hit || req_lat.op)) || refill_match;

endmodule

// File: logic/dcache_miss_ctrl.sv
`include "dcache_params.svh"

module dcache_miss_ctrl (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    valid,      // request taken this cycle
    input  dcache_pkg::cpu_req_t    req_lat,
    input  logic                    hit,
    input  dcache_pkg::wbuf_t       wbuf,
    input  dcache_pkg::way_q_t      way0_q,
    input  dcache_pkg::way_q_t      way1_q,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  dcache_pkg::word_t       ret_data,
    input  logic                    wr_rdy,
    output dcache_pkg::main_state_e state,
    output dcache_pkg::bank_t       beat,
    output dcache_pkg::way_wr_t     way0_wr,
    output dcache_pkg::way_wr_t     way1_wr,
    output logic                    rd_req,
    output dcache_pkg::word_t       rd_addr,
    output logic                    wr_req,
    output dcache_pkg::word_t       wr_addr,
    output dcache_pkg::line_t       wr_data
);

    dcache_pkg::main_state_e state_nxt;
    logic [7:0]              lfsr;
    dcache_pkg::way_sel_t    pick_sel;
    dcache_pkg::way_q_t      pick_q;
    logic                    wbuf_on_pick;
    dcache_pkg::line_t       pick_line;
    dcache_pkg::way_sel_t    victim_sel;
    logic                    victim_dirty;
    dcache_pkg::tag_t        victim_tag;
    dcache_pkg::line_t       victim_line;
    dcache_pkg::bank_t       req_bank;
    dcache_pkg::word_t       refill_word;
    logic                    refill_go;
    dcache_pkg::way_wr_t     wr_port [`DC_WAYS];

    assign req_bank  = req_lat.offset[`DC_OFFSET_W-1:2];
    assign refill_go = state == dcache_pkg::REFILL && ret_valid;

    assign pick_sel = lfsr[0] ? dcache_pkg::way_sel_t'(2) : dcache_pkg::way_sel_t'(1);
    assign pick_q   = lfsr[0] ? way1_q : way0_q;

    // q was read before the buffered store landed, so patch it in
    assign wbuf_on_pick = wbuf.valid && wbuf.index == req_lat.index && wbuf.way == pick_sel;

    always_comb begin
        pick_line = pick_q.line;
        for (int k = 0; k < `DC_WORD_W / 8; k++) begin
            if (wbuf_on_pick && wbuf.strb[k]) begin
                pick_line[{wbuf.bank, 5'd0} + 8*k +: 8] = wbuf.word[8*k +: 8];
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::IDLE:    if (valid) state_nxt = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP:  state_nxt = !hit ? dcache_pkg::MISS :
                                              valid ? dcache_pkg::LOOKUP : dcache_pkg::IDLE;
            dcache_pkg::MISS: begin
                if (victim_dirty) begin
                    if (wr_rdy && !wr_req) state_nxt = dcache_pkg::REPLACE;
                end else if (rd_req && rd_rdy) begin
                    state_nxt = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REPLACE: if (rd_req && rd_rdy) state_nxt = dcache_pkg::REFILL;
            dcache_pkg::REFILL:  if (ret_valid && ret_last) state_nxt = dcache_pkg::IDLE;
            default:             state_nxt = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= dcache_pkg::IDLE;
            lfsr         <= `DC_LFSR_SEED;
            beat         <= '0;
            rd_req       <= 1'b0;
            wr_req       <= 1'b0;
            victim_sel   <= '0;
            victim_dirty <= 1'b0;
        end else begin
            state <= state_nxt;
            lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (refill_go) begin
                beat <= ret_last ? '0 : dcache_pkg::bank_t'(beat + 1'b1);
            end
            if (rd_req && rd_rdy) begin
                rd_req <= 1'b0;
            end else if ((state == dcache_pkg::MISS && !victim_dirty) ||
                         state == dcache_pkg::REPLACE) begin
                rd_req <= 1'b1;
            end
            if (state == dcache_pkg::MISS && state_nxt == dcache_pkg::REPLACE) begin
                wr_req <= 1'b1;
            end else if (wr_rdy) begin
                wr_req <= 1'b0;
            end
            if (state == dcache_pkg::LOOKUP && !hit) begin
                victim_sel   <= pick_sel;
                victim_dirty <= pick_q.valid && (pick_q.dirty || wbuf_on_pick);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::LOOKUP && !hit) begin
            victim_tag  <= pick_q.tag;
            victim_line <= pick_line;
        end
    end

    assign rd_addr = {req_lat.tag, req_lat.index, dcache_pkg::offset_t'(0)};
    assign wr_addr = {victim_tag, req_lat.index, dcache_pkg::offset_t'(0)};
    assign wr_data = victim_line;

    // pending store lands on its own word of the refill
    always_comb begin
        refill_word = ret_data;
        for (int k = 0; k < `DC_WORD_W / 8; k++) begin
            if (req_lat.op && beat == req_bank && req_lat.wstrb[k]) begin
                refill_word[8*k +: 8] = req_lat.wdata[8*k +: 8];
            end
        end
    end

    // refill takes the port first
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            wr_port[w] = '0;
            if (refill_go && victim_sel[w]) begin
                wr_port[w].word_we   = 1'b1;
                wr_port[w].bank      = beat;
                wr_port[w].strb      = '1;
                wr_port[w].word      = refill_word;
                wr_port[w].tag_we    = ret_last;
                wr_port[w].tag       = req_lat.tag;
                wr_port[w].set_dirty = ret_last && req_lat.op;
                wr_port[w].clr_dirty = ret_last && !req_lat.op;
                wr_port[w].index     = req_lat.index;
            end else if (wbuf.valid && wbuf.way[w]) begin
                wr_port[w].word_we   = 1'b1;
                wr_port[w].bank      = wbuf.bank;
                wr_port[w].strb      = wbuf.strb;
                wr_port[w].word      = wbuf.word;
                wr_port[w].set_dirty = 1'b1;
                wr_port[w].index     = wbuf.index;
            end
        end
    end

    assign way0_wr = wr_port[0];
    assign way1_wr = wr_port[1];

endmodule

// File: logic/dcache_lookup.sv
`include "dcache_params.svh"

module dcache_lookup (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    valid,
    input  dcache_pkg::cpu_req_t    req,
    input  dcache_pkg::main_state_e state,
    input  dcache_pkg::way_q_t      way0_q,
    input  dcache_pkg::way_q_t      way1_q,
    output logic                    addr_ok,
    output logic                    rd_en,
    output dcache_pkg::index_t      rd_index,
    output dcache_pkg::cpu_req_t    req_lat,
    output logic                    hit,
    output dcache_pkg::way_sel_t    hit_way,
    output dcache_pkg::wbuf_t       wbuf
);

    dcache_pkg::bank_t req_bank;
    dcache_pkg::bank_t lat_bank;
    logic              in_lookup;
    logic              wbuf_hazard;
    logic              lookup_hazard;
    logic              bank_conflict;
    logic              wbuf_load;

    assign req_bank  = req.offset[`DC_OFFSET_W-1:2];
    assign lat_bank  = req_lat.offset[`DC_OFFSET_W-1:2];
    assign in_lookup = state == dcache_pkg::LOOKUP;

    // store sitting in the write buffer, written this cycle
    assign wbuf_hazard = wbuf.valid && wbuf.bank == req_bank;
    // store being compared now, written next cycle
    assign lookup_hazard = in_lookup && req_lat.op && lat_bank == req_bank;

    // only loads are held back, stores queue up in order
    assign bank_conflict = valid && !req.op && (wbuf_hazard || lookup_hazard);

    assign addr_ok  = (state == dcache_pkg::IDLE || (in_lookup && hit)) && !bank_conflict;
    assign rd_en    = valid && addr_ok;
    assign rd_index = req.index;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_lat <= req;
        end
    end

    // q holds the set read on acceptance
    assign hit_way[0] = way0_q.valid && way0_q.tag == req_lat.tag;
    assign hit_way[1] = way1_q.valid && way1_q.tag == req_lat.tag;
    assign hit        = |hit_way;

    assign wbuf_load = in_lookup && hit && req_lat.op;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wbuf.valid <= 1'b0;
        end else begin
            wbuf.valid <= wbuf_load;   // one cycle only
        end
        if (wbuf_load) begin
            wbuf.way   <= hit_way;
            wbuf.index <= req_lat.index;
            wbuf.bank  <= lat_bank;
            wbuf.strb  <= req_lat.wstrb;
            wbuf.word  <= req_lat.wdata;
        end
    end

endmodule

// File: logic/dcache_way_store.sv
`include "dcache_params.svh"

module dcache_way_store (
    input  logic                clk,
    input  logic                resetn,
    input  logic                rd_en,
    input  dcache_pkg::index_t  rd_index,
    input  dcache_pkg::way_wr_t wr,
    output dcache_pkg::way_q_t  q
);

    logic [`DC_SETS-1:0] valid_tbl;
    logic [`DC_SETS-1:0] dirty_tbl;
    dcache_pkg::tag_t    tag_mem [`DC_SETS];
    dcache_pkg::word_t   bank_mem [`DC_BANKS][`DC_SETS];
    dcache_pkg::word_t   wr_merged;
    logic                same_index;

    assign same_index = wr.index == rd_index;

    // stored word with the strobed bytes replaced
    always_comb begin
        wr_merged = bank_mem[wr.bank][wr.index];
        for (int k = 0; k < `DC_WORD_W / 8; k++) begin
            if (wr.strb[k]) begin
                wr_merged[8*k +: 8] = wr.word[8*k +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_tbl <= '0;
            dirty_tbl <= '0;
        end else begin
            if (wr.tag_we) begin
                valid_tbl[wr.index] <= 1'b1;
            end
            if (wr.set_dirty) begin
                dirty_tbl[wr.index] <= 1'b1;
            end else if (wr.clr_dirty) begin
                dirty_tbl[wr.index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.tag_we) begin
            tag_mem[wr.index] <= wr.tag;
        end
        if (wr.word_we) begin
            bank_mem[wr.bank][wr.index] <= wr_merged;
        end
    end

    // write-first: a store into the set being read shows up in q
    always_ff @(posedge clk) begin
        if (rd_en) begin
            q.valid <= valid_tbl[rd_index] || (wr.tag_we && same_index);
            if (wr.set_dirty && same_index) begin
                q.dirty <= 1'b1;
            end else if (wr.clr_dirty && same_index) begin
                q.dirty <= 1'b0;
            end else begin
                q.dirty <= dirty_tbl[rd_index];
            end
            q.tag <= (wr.tag_we && same_index) ? wr.tag : tag_mem[rd_index];
            for (int b = 0; b < `DC_BANKS; b++) begin
                if (wr.word_we && same_index && wr.bank == b) begin
                    q.line[b*`DC_WORD_W +: `DC_WORD_W] <= wr_merged;
                end else begin
                    q.line[b*`DC_WORD_W +: `DC_WORD_W] <= bank_mem[b][rd_index];
                end
            end
        end
    end

endmodule

// File: logic/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W-1:0]          tag_t;
    typedef logic [`DC_INDEX_W-1:0]        index_t;
    typedef logic [`DC_OFFSET_W-1:0]       offset_t;
    typedef logic [`DC_WORD_W-1:0]         word_t;
    typedef logic [`DC_WORD_W/8-1:0]       strb_t;
    typedef logic [$clog2(`DC_BANKS)-1:0]  bank_t;
    typedef logic [`DC_LINE_W-1:0]         line_t;
    typedef logic [`DC_WAYS-1:0]           way_sel_t;   // one-hot

    typedef struct packed {
        logic    op;        // 1 = store
        index_t  index;
        tag_t    tag;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_q_t;

    typedef struct packed {
        logic   word_we;
        bank_t  bank;
        strb_t  strb;
        word_t  word;
        logic   tag_we;     // also marks the set valid
        tag_t   tag;
        logic   set_dirty;
        logic   clr_dirty;
        index_t index;
    } way_wr_t;

    typedef struct packed {
        logic     valid;
        way_sel_t way;
        index_t   index;
        bank_t    bank;
        strb_t    strb;
        word_t    word;
    } wbuf_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_e;

endpackage

// File: include/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// address split, tag | index | byte offset
`define DC_TAG_W        20
`define DC_INDEX_W      8
`define DC_OFFSET_W     4

// data path
`define DC_WORD_W       32
`define DC_BANKS        4      // words per line
`define DC_LINE_W       128

// organisation
`define DC_WAYS         2
`define DC_SETS         256

// victim lfsr, must not be zero
`define DC_LFSR_SEED    8'h5a

`endif
